// File: hdl/fprint_pkg.sv
`default_nettype none

package fprint_pkg;

	localparam int CRC_WIDTH           = 16;
	localparam int TASK_ID_WIDTH       = 4;
	localparam int NUM_TASKS           = 16;
	localparam int WORD_WIDTH          = 32;
	// per task, per core; keep it a power of two
	localparam int DEFAULT_QUEUE_DEPTH = 4;

	typedef enum logic {
		WORD_FPRINT  = 1'b0,
		WORD_CHECKIN = 1'b1
	} word_kind_e;

	typedef logic [TASK_ID_WIDTH-1:0] task_id_t;

	// one core word, read as fingerprint or as check-in depending on kind
	typedef union packed {
		struct packed {
			word_kind_e           kind;
			task_id_t             task_id;
			logic [10:0]          unused;
			logic [CRC_WIDTH-1:0] crc;
		} fprint;
		struct packed {
			word_kind_e  kind;
			task_id_t    task_id;
			logic [26:0] reserved;
		} checkin;
	} core_word_u;

endpackage

`default_nettype wire

// File: hdl/cmp_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cmp_if import fprint_pkg::*; ();

	// buffer side status
	logic [NUM_TASKS-1:0] fprints_ready;
	logic [NUM_TASKS-1:0] checkin;
	logic [CRC_WIDTH-1:0] fprint_0;
	logic [CRC_WIDTH-1:0] fprint_1;
	logic                 tail0_matches_head0;
	logic                 tail1_matches_head1;
	logic                 head0_matches_head1;
	logic                 clear_ack;

	// comparator requests
	task_id_t             task_id;
	logic                 increment_tail;
	logic                 clear_task;

	modport ctrl (
		input  fprints_ready, checkin, fprint_0, fprint_1,
		input  tail0_matches_head0, tail1_matches_head1, head0_matches_head1, clear_ack,
		output task_id, increment_tail, clear_task
	);

	modport buffer (
		output fprints_ready, checkin, fprint_0, fprint_1,
		output tail0_matches_head0, tail1_matches_head1, head0_matches_head1, clear_ack,
		input  task_id, increment_tail, clear_task
	);

endinterface

`default_nettype wire

// File: hdl/fprint_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module fprint_buffer import fprint_pkg::*; #(
	parameter int QUEUE_DEPTH = DEFAULT_QUEUE_DEPTH
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       core0_valid,
	input  logic       core1_valid,
	input  core_word_u core0_word,
	input  core_word_u core1_word,
	cmp_if.buffer      cmp
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	logic [1:0]           valid;
	core_word_u           word [2];

	logic [CRC_WIDTH-1:0] mem [2][NUM_TASKS][QUEUE_DEPTH];
	// head is written by the core, tail is read by the comparator
	logic [PTR_W:0]       head [2][NUM_TASKS];
	logic [PTR_W:0]       tail [2][NUM_TASKS];
	logic [NUM_TASKS-1:0] checked_in [2];

	task_id_t             push_task [2];
	logic [PTR_W-1:0]     push_slot [2];
	logic [1:0]           push;
	logic [1:0]           is_checkin;
	logic [NUM_TASKS-1:0] ready;
	logic                 clear_ack_q;
	logic                 do_clear;
	task_id_t             sel;

	assign valid   = {core1_valid, core0_valid};
	assign word[0] = core0_word;
	assign word[1] = core1_word;

	// decode kind first, then take the matching view
	always_comb begin
		for (int c = 0; c < 2; c++) begin
			is_checkin[c] = valid[c] && (word[c].fprint.kind == WORD_CHECKIN);
			push_task[c]  = word[c].fprint.task_id;
			push_slot[c]  = head[c][push_task[c]][PTR_W-1:0];
			// full when the slot bits agree but the wrap bits differ
			push[c] = valid[c] && (word[c].fprint.kind == WORD_FPRINT) &&
				((head[c][push_task[c]] ^ tail[c][push_task[c]]) != {1'b1, {PTR_W{1'b0}}});
		end
	end

	always_ff @(posedge clk) begin
		for (int c = 0; c < 2; c++) begin
			if (push[c])
				mem[c][push_task[c]][push_slot[c]] <= word[c].fprint.crc;
		end
	end

	// one clear per request, the ack cycle does nothing
	assign do_clear = cmp.clear_task && !clear_ack_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			head        <= '{default: '0};
			tail        <= '{default: '0};
			checked_in  <= '{default: '0};
			clear_ack_q <= 1'b0;
		end else begin
			clear_ack_q <= do_clear;
			for (int c = 0; c < 2; c++) begin
				if (push[c])
					head[c][push_task[c]] <= head[c][push_task[c]] + 1'b1;
				if (is_checkin[c])
					checked_in[c][word[c].checkin.task_id] <= 1'b1;
				if (cmp.increment_tail)
					tail[c][cmp.task_id] <= tail[c][cmp.task_id] + 1'b1;
				// clear wins over a push to the same task in that cycle
				if (do_clear) begin
					head[c][cmp.task_id]       <= '0;
					tail[c][cmp.task_id]       <= '0;
					checked_in[c][cmp.task_id] <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		for (int t = 0; t < NUM_TASKS; t++)
			ready[t] = (head[0][t] != tail[0][t]) && (head[1][t] != tail[1][t]);
	end

	assign sel = cmp.task_id;

	assign cmp.fprints_ready       = ready;
	assign cmp.checkin             = checked_in[0] & checked_in[1];
	assign cmp.fprint_0            = mem[0][sel][tail[0][sel][PTR_W-1:0]];
	assign cmp.fprint_1            = mem[1][sel][tail[1][sel][PTR_W-1:0]];
	assign cmp.tail0_matches_head0 = (tail[0][sel] == head[0][sel]);
	assign cmp.tail1_matches_head1 = (tail[1][sel] == head[1][sel]);
	assign cmp.head0_matches_head1 = (head[0][sel] == head[1][sel]);
	assign cmp.clear_ack           = clear_ack_q;

endmodule

`default_nettype wire

// File: hdl/task_status.sv
`timescale 1ns/100ps
`default_nettype none

module task_status import fprint_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     status_write,
	input  logic     mismatch,
	input  task_id_t task_id,
	output logic     status_ack,
	output logic     result_valid,
	output logic     result_mismatch,
	output task_id_t result_task
);

	// last verdict per task, 1 means mismatch
	logic [NUM_TASKS-1:0] verdict;
	logic                 take;

	// status_write is a level, accept it once
	assign take = status_write && !status_ack;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			verdict      <= '0;
			status_ack   <= 1'b0;
			result_valid <= 1'b0;
			result_task  <= '0;
		end else begin
			status_ack   <= take;
			result_valid <= take;
			if (take) begin
				verdict[task_id] <= mismatch;
				result_task      <= task_id;
			end
		end
	end

	assign result_mismatch = verdict[result_task];

endmodule

`default_nettype wire

// File: hdl/comparator.sv
`timescale 1ns/100ps
`default_nettype none

module comparator import fprint_pkg::*; #(
	parameter int QUEUE_DEPTH = DEFAULT_QUEUE_DEPTH
) (
	input  logic     clk,
	input  logic     reset,
	cmp_if.ctrl      cmp,
	output logic     status_write,
	output logic     mismatch,
	output task_id_t task_id,
	input  logic     status_ack
);

	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	localparam logic [3:0] idle                   = 4'd0;
	localparam logic [3:0] set_task               = 4'd1;
	localparam logic [3:0] check_task_status      = 4'd2;
	localparam logic [3:0] compare_fprints        = 4'd3;
	localparam logic [3:0] increment_tail_pointer = 4'd4;
	localparam logic [3:0] check_if_done          = 4'd5;
	localparam logic [3:0] task_complete          = 4'd6;
	localparam logic [3:0] mismatch_detected      = 4'd7;
	localparam logic [3:0] st_clear_task          = 4'd8;
	localparam logic [3:0] write_status           = 4'd9;

	logic [3:0]           state;
	logic [NUM_TASKS-1:0] pending;
	task_id_t             next_task;
	logic                 queue_empty;
	// pairs drained since the task was locked
	logic [CNT_W-1:0]     pair_count;

	// lowest task with work wins
	always_comb begin
		pending   = cmp.fprints_ready | cmp.checkin;
		next_task = '0;
		for (int i = NUM_TASKS - 1; i >= 0; i--) begin
			if (pending[i])
				next_task = task_id_t'(i);
		end
	end

	assign queue_empty = cmp.tail0_matches_head0 || cmp.tail1_matches_head1;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle:
					if (|pending)
						state <= set_task;
				set_task:
					state <= check_task_status;
				check_task_status:
					if (cmp.fprints_ready[task_id])
						state <= compare_fprints;
					else if (cmp.checkin[task_id])
						state <= task_complete;
					else
						state <= idle;
				compare_fprints:
					if (cmp.fprint_0 == cmp.fprint_1)
						state <= increment_tail_pointer;
					else
						state <= mismatch_detected;
				increment_tail_pointer:
					state <= check_if_done;
				check_if_done:
					// pointers already reflect the pop here
					if (queue_empty)
						state <= cmp.checkin[task_id] ? task_complete : idle;
					else if (pair_count == CNT_W'(QUEUE_DEPTH))
						state <= idle;
					else
						state <= compare_fprints;
				task_complete:
					// both cores checked in, counts must agree
					if (cmp.head0_matches_head1)
						state <= st_clear_task;
					else
						state <= mismatch_detected;
				mismatch_detected:
					state <= st_clear_task;
				st_clear_task:
					if (cmp.clear_ack)
						state <= write_status;
				write_status:
					if (status_ack)
						state <= idle;
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			task_id    <= '0;
			mismatch   <= 1'b0;
			pair_count <= '0;
		end else begin
			// lock the task, the encoder may change under us
			if (state == set_task) begin
				task_id    <= next_task;
				pair_count <= '0;
			end
			if (state == increment_tail_pointer)
				pair_count <= pair_count + 1'b1;
			if (state == mismatch_detected)
				mismatch <= 1'b1;
			else if (state == idle)
				mismatch <= 1'b0;
		end
	end

	assign cmp.task_id        = task_id;
	assign cmp.increment_tail = (state == increment_tail_pointer);
	assign cmp.clear_task     = (state == st_clear_task);
	assign status_write       = (state == write_status);

endmodule

`default_nettype wire

// File: hdl/fprint_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fprint_unit import fprint_pkg::*; #(
	parameter int QUEUE_DEPTH = DEFAULT_QUEUE_DEPTH
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  core0_valid,
	input  logic [WORD_WIDTH-1:0] core0_word,
	input  logic                  core1_valid,
	input  logic [WORD_WIDTH-1:0] core1_word,
	output logic                  result_valid,
	output task_id_t              result_task,
	output logic                  result_mismatch
);

	cmp_if cmp_bus ();

	logic     status_write;
	logic     status_mismatch;
	logic     status_ack;
	task_id_t status_task;

	fprint_buffer #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_fprint_buffer (
		.clk         (clk),
		.reset       (reset),
		.core0_valid (core0_valid),
		.core1_valid (core1_valid),
		.core0_word  (core_word_u'(core0_word)),
		.core1_word  (core_word_u'(core1_word)),
		.cmp         (cmp_bus)
	);

	comparator #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_comparator (
		.clk          (clk),
		.reset        (reset),
		.cmp          (cmp_bus),
		.status_write (status_write),
		.mismatch     (status_mismatch),
		.task_id      (status_task),
		.status_ack   (status_ack)
	);

	task_status u_task_status (
		.clk             (clk),
		.reset           (reset),
		.status_write    (status_write),
		.mismatch        (status_mismatch),
		.task_id         (status_task),
		.status_ack      (status_ack),
		.result_valid    (result_valid),
		.result_mismatch (result_mismatch),
		.result_task     (result_task)
	);

endmodule

`default_nettype wire

// File: sim/fprint_unit_sva.sv
`timescale 1ns/100ps
`default_nettype none

module fprint_unit_sva (
	input logic clk,
	input logic reset,
	input logic status_write,
	input logic status_ack,
	input logic clear_task,
	input logic clear_ack,
	input logic increment_tail,
	input logic queue0_empty,
	input logic queue1_empty
);

	// requests are levels, held until the acknowledge comes back
	status_held: assert property (@(posedge clk) disable iff (reset)
		status_write && !status_ack |=> status_write)
		else $error("status_write dropped before status_ack");

	clear_held: assert property (@(posedge clk) disable iff (reset)
		clear_task && !clear_ack |=> clear_task)
		else $error("clear_task dropped before clear_ack");

	// a pop needs an entry in both queues
	pop_needs_entries: assert property (@(posedge clk) disable iff (reset)
		increment_tail |-> !(queue0_empty || queue1_empty))
		else $error("increment_tail while a queue is empty");

endmodule

bind comparator fprint_unit_sva u_sva (
	.clk            (clk),
	.reset          (reset),
	.status_write   (status_write),
	.status_ack     (status_ack),
	.clear_task     (cmp.clear_task),
	.clear_ack      (cmp.clear_ack),
	.increment_tail (cmp.increment_tail),
	.queue0_empty   (cmp.tail0_matches_head0),
	.queue1_empty   (cmp.tail1_matches_head1)
);

`default_nettype wire

// File: sim/fprint_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fprint_unit_tb import fprint_pkg::*; ();

	localparam int MAX_FPRINTS = 3;
	localparam int WAIT_LIMIT  = 400;

	logic                  clk;
	logic                  reset;
	logic                  core0_valid;
	logic [WORD_WIDTH-1:0] core0_word;
	logic                  core1_valid;
	logic [WORD_WIDTH-1:0] core1_word;
	logic                  result_valid;
	task_id_t              result_task;
	logic                  result_mismatch;

	// what each core sends per task
	logic [CRC_WIDTH-1:0]  crc0 [NUM_TASKS][MAX_FPRINTS];
	logic [CRC_WIDTH-1:0]  crc1 [NUM_TASKS][MAX_FPRINTS];
	int                    cnt0 [NUM_TASKS];
	int                    cnt1 [NUM_TASKS];
	logic [WORD_WIDTH-1:0] stream0 [$];
	logic [WORD_WIDTH-1:0] stream1 [$];
	task_id_t              exp_task [$];
	logic                  exp_mismatch [$];
	logic [31:0]           lfsr;
	int                    checks;
	int                    mismatches;
	int                    failures;

	fprint_unit #(
		.QUEUE_DEPTH (DEFAULT_QUEUE_DEPTH)
	) uut (
		.clk             (clk),
		.reset           (reset),
		.core0_valid     (core0_valid),
		.core0_word      (core0_word),
		.core1_valid     (core1_valid),
		.core1_word      (core1_word),
		.result_valid    (result_valid),
		.result_task     (result_task),
		.result_mismatch (result_mismatch)
	);

	always #5 clk = ~clk;

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// any differing pair or unequal counts is a mismatch
	function automatic logic expected_mismatch(input task_id_t t);
		if (cnt0[t] != cnt1[t])
			return 1'b1;
		for (int i = 0; i < cnt0[t]; i++) begin
			if (crc0[t][i] != crc1[t][i])
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic fill_task(input task_id_t t, input int n0, input int n1);
		cnt0[t] = n0;
		cnt1[t] = n1;
		for (int i = 0; i < MAX_FPRINTS; i++) begin
			crc0[t][i] = CRC_WIDTH'(random_bits(CRC_WIDTH));
			crc1[t][i] = crc0[t][i];
		end
	endtask

	// fingerprints first, check-in last, one contiguous block per core
	task automatic append_words(input int core, input task_id_t t);
		if (core == 0) begin
			for (int i = 0; i < cnt0[t]; i++)
				stream0.push_back({1'b0, t, 11'h000, crc0[t][i]});
			stream0.push_back({1'b1, t, 27'h0});
		end else begin
			for (int i = 0; i < cnt1[t]; i++)
				stream1.push_back({1'b0, t, 11'h000, crc1[t][i]});
			stream1.push_back({1'b1, t, 27'h0});
		end
	endtask

	task automatic expect_verdict(input task_id_t t);
		exp_task.push_back(t);
		exp_mismatch.push_back(expected_mismatch(t));
	endtask

	task automatic queue_task(input task_id_t t);
		append_words(0, t);
		append_words(1, t);
		expect_verdict(t);
	endtask

	task automatic send_streams();
		while (stream0.size() > 0 || stream1.size() > 0) begin
			@(posedge clk);
			#1;
			core0_valid = (stream0.size() > 0);
			core0_word  = (stream0.size() > 0) ? stream0.pop_front() : '0;
			core1_valid = (stream1.size() > 0);
			core1_word  = (stream1.size() > 0) ? stream1.pop_front() : '0;
		end
		@(posedge clk);
		#1;
		core0_valid = 1'b0;
		core1_valid = 1'b0;
	endtask

	task automatic finish_run();
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		while (exp_task.size() > 0 && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_task.size() > 0) begin
			failures++;
			$display("Timeout at %0t: %0d verdicts never arrived", $time, exp_task.size());
			finish_run();
		end
	endtask

	// verdicts come out in FSM order, so match them by task
	always @(negedge clk) begin : compare_results
		int idx;
		if (!reset && result_valid) begin
			idx = -1;
			for (int i = 0; i < exp_task.size(); i++) begin
				if (idx < 0 && exp_task[i] == result_task)
					idx = i;
			end
			if (idx < 0) begin
				failures++;
				$display("Unexpected verdict at %0t for task %0d", $time, result_task);
			end else begin
				checks++;
				if (result_mismatch !== exp_mismatch[idx]) begin
					mismatches++;
					$display("Mismatch at %0t: task %0d verdict %0b, expected %0b",
						$time, result_task, result_mismatch, exp_mismatch[idx]);
				end
				exp_task.delete(idx);
				exp_mismatch.delete(idx);
			end
		end
	end

	initial begin : main
		task_id_t t;
		int       n0;
		int       n1;
		int       p;
		clk         = 1'b0;
		reset       = 1'b1;
		core0_valid = 1'b0;
		core0_word  = '0;
		core1_valid = 1'b0;
		core1_word  = '0;
		lfsr        = 32'h2419;
		checks      = 0;
		mismatches  = 0;
		failures    = 0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		if (result_valid !== 1'b0) begin
			mismatches++;
			$display("Mismatch at %0t: result_valid is %b after reset", $time, result_valid);
		end

		// matching streams of one to three fingerprints
		for (int n = 1; n <= MAX_FPRINTS; n++) begin
			fill_task(4'd1, n, n);
			queue_task(4'd1);
			send_streams();
			wait_results();
		end

		// one flipped bit in the middle pair
		fill_task(4'd5, 3, 3);
		crc1[5][1] = crc0[5][1] ^ CRC_WIDTH'(32'h1 << random_bits(4));
		queue_task(4'd5);
		// equal pairs, core1 one short
		fill_task(4'd7, 3, 2);
		queue_task(4'd7);
		send_streams();
		wait_results();

		// four tasks in flight, core1 sends them in a rotated order
		for (int r = 0; r < 3; r++) begin
			for (int k = 0; k < 4; k++) begin
				t  = task_id_t'(8 + k);
				n0 = 1 + int'(random_bits(2) % 3);
				n1 = (random_bits(3) == 0) ? 1 + (n0 % 3) : n0;
				fill_task(t, n0, n1);
				if (random_bits(2) == 0) begin
					p = int'(random_bits(2)) % ((n0 < n1) ? n0 : n1);
					crc1[t][p] = crc1[t][p] ^ CRC_WIDTH'(32'h1 << random_bits(4));
				end
				expect_verdict(t);
			end
			for (int k = 0; k < 4; k++) begin
				append_words(0, task_id_t'(8 + k));
				append_words(1, task_id_t'(8 + (k + r + 1) % 4));
			end
			send_streams();
			wait_results();
		end

		// tasks that failed earlier start again from empty queues
		fill_task(4'd5, 2, 2);
		queue_task(4'd5);
		fill_task(4'd7, 1, 1);
		queue_task(4'd7);
		send_streams();
		wait_results();

		// window for late or repeated verdicts
		repeat (50) @(posedge clk);
		finish_run();
	end

endmodule

`default_nettype wire

// File: fprint_unit.f
hdl/fprint_pkg.sv
hdl/cmp_if.sv
hdl/fprint_buffer.sv
hdl/task_status.sv
hdl/comparator.sv
hdl/fprint_unit.sv
sim/fprint_unit_sva.sv
sim/fprint_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fprint_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fprint_unit_tb -f fprint_unit.f

out=$(./obj_dir/Vfprint_unit_tb || true)
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
